// ==== dsp_cfg_pkg.sv ====
/* widths and counts shared across the readout design: samples, accumulator,
   buffer address, shot count and lane count */
package dsp_cfg_pkg;

	// adc and local oscillator samples, two's complement
	localparam int sample_w = 16;

	// one half of the accumulator word, x or y
	localparam int acc_half_w = 32;

	// full word written to the accumulation buffer
	localparam int acc_w = 2 * acc_half_w;

	// buffer depth is 2**accbuf_addr_w entries
	// default for the top level address width parameter
	localparam int accbuf_addr_w = 4;

	// shot counter and requested shot count
	localparam int shot_w = 32;

	// readout lanes side by side
	localparam int n_lane = 2;

	// right shift applied to each product before accumulation
	localparam int shift_w = 4;

endpackage

// ==== dsp_types_pkg.sv ====
/* packed types passed between the sequencer, the readout lanes and the
   measurement collector */
package dsp_types_pkg;
	import dsp_cfg_pkg::*;

	// per-cycle lane input, adc stream plus lo pair and gate
	typedef struct packed {
		logic [sample_w-1:0] sample;
		logic [sample_w-1:0] lo_x;
		logic [sample_w-1:0] lo_y;
		logic                gate;
	} lane_in_t;

	// x in the upper half, y in the lower half
	typedef struct packed {
		logic signed [acc_half_w-1:0] acc_x;
		logic signed [acc_half_w-1:0] acc_y;
	} acc_xy_t;

	// raw buffer word or split accumulator pair
	typedef union packed {
		logic [acc_w-1:0] raw;
		acc_xy_t          xy;
	} acc_word_t;

	// address field sized at the default buffer width
	typedef struct packed {
		logic                     we;
		logic [accbuf_addr_w-1:0] addr;
		acc_word_t                data;
	} accbuf_wr_t;

	// threshold bit toward the collector
	typedef struct packed {
		logic valid;
		logic meas;
	} lane_result_t;

	// one word per readout event, bit i belongs to lane i
	typedef struct packed {
		logic              valid;
		logic [n_lane-1:0] bits;
		logic [n_lane-1:0] mask;
		logic [shot_w-1:0] shot;
	} meas_t;

endpackage

// ==== shot_sequencer.sv ====
`timescale 1ns/1ns
/* experiment state machine with shot counting, processor reset control
   and the last-shot-done level */
module shot_sequencer (
	input  logic                           dspif,
	input  logic                           rst_n,
	input  logic                           stb_start,
	input  logic [dsp_cfg_pkg::shot_w-1:0] nshot,
	input  logic                           proc_done,
	input  logic                           no_busy,
	output logic                           proc_reset,
	output logic [dsp_cfg_pkg::shot_w-1:0] shot_cnt,
	output logic                           last_shot_done
);
	import dsp_cfg_pkg::*;

	// gray-like encoding, neighbours differ in one bit
	typedef enum logic [2:0] {
		st_idle      = 3'b000,
		st_start     = 3'b001,
		st_run       = 3'b011,
		st_wait_busy = 3'b010,
		st_more_shot = 3'b110,
		st_shot_add  = 3'b111,
		st_done      = 3'b101
	} state_t;

	state_t            state;
	state_t            next_state;
	logic [shot_w-1:0] nshot_r;
	logic [shot_w-1:0] shot_idx;
	logic [shot_w-1:0] next_idx;
	logic              proc_done_r;
	logic              no_busy_r;
	logic              shot_add;
	logic              done;

	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			st_idle:      if (stb_start) next_state = st_start;
			st_start:     next_state = st_run;
			// wait for the processors to finish the shot
			st_run:       if (proc_done_r) next_state = st_wait_busy;
			// then for all elements to go idle
			st_wait_busy: if (no_busy_r) next_state = st_more_shot;
			st_more_shot: next_state = shot_add ? st_shot_add : st_done;
			st_shot_add:  next_state = st_start;
			st_done:      next_state = st_idle;
			default:      next_state = st_idle;
		endcase
	end

	// one register stage on the processor levels
	// next-count compare settled well before more-shot
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			proc_done_r <= 1'b0;
			no_busy_r   <= 1'b0;
			next_idx    <= '0;
			shot_add    <= 1'b0;
		end else begin
			proc_done_r <= proc_done;
			no_busy_r   <= no_busy;
			next_idx    <= shot_idx + 1'b1;
			// nshot of zero keeps shooting forever
			shot_add    <= (next_idx != nshot_r) || (nshot_r == '0);
		end
	end

	// outputs follow next_state so they line up with the state register
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			proc_reset <= 1'b1;
			done       <= 1'b0;
			shot_idx   <= '0;
			shot_cnt   <= '0;
			nshot_r    <= '0;
		end else begin
			// processors run only in start and run
			proc_reset <= !(next_state == st_start || next_state == st_run);
			done       <= (next_state == st_done);
			case (next_state)
				st_idle: begin
					shot_idx <= '0;
					nshot_r  <= nshot;
				end
				st_shot_add: begin
					shot_idx <= next_idx;
					// publish index of the shot just finished
					shot_cnt <= shot_idx;
				end
				st_done:  shot_idx <= '0;
				default:  shot_idx <= shot_idx;
			endcase
		end
	end

	// set by done, cleared by the next start request
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			last_shot_done <= 1'b0;
		end else if (done || stb_start) begin
			last_shot_done <= done && !stb_start;
		end
	end

endmodule

// ==== readout_lane.sv ====
`timescale 1ns/1ns
/* gated mix and accumulate for one readout channel, with accumulation
   buffer write pointer and threshold bit */
module readout_lane #(
	parameter int ACCBUF_ADDR_W = dsp_cfg_pkg::accbuf_addr_w
) (
	input  logic                            dspif,
	input  logic                            rst_n,
	input  logic                            resetacc,
	input  logic [dsp_cfg_pkg::shift_w-1:0] shift,
	input  dsp_types_pkg::lane_in_t         lin,
	output dsp_types_pkg::accbuf_wr_t       wr,
	output dsp_types_pkg::lane_result_t     res
);
	import dsp_cfg_pkg::*;
	import dsp_types_pkg::*;

	lane_in_t                     lin_r;
	logic                         gate_d;
	logic                         gate_fall;
	logic signed [acc_half_w-1:0] prod_x;
	logic signed [acc_half_w-1:0] prod_y;
	acc_word_t                    acc;
	acc_word_t                    wr_data;
	logic                         we;
	logic [ACCBUF_ADDR_W-1:0]     ptr;
	logic                         lock_last;
	logic                         res_valid;
	logic                         res_meas;

	// input stage, samples and gate together
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			lin_r  <= '0;
			gate_d <= 1'b0;
		end else begin
			lin_r  <= lin;
			gate_d <= lin_r.gate;
		end
	end

	always_comb begin
		// full precision signed products
		prod_x    = $signed(lin_r.sample) * $signed(lin_r.lo_x);
		prod_y    = $signed(lin_r.sample) * $signed(lin_r.lo_y);
		gate_fall = gate_d && !lin_r.gate;
		lock_last = &ptr;
	end

	// wrapping accumulators, cleared as the result is handed off
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			acc <= '0;
		end else if (gate_fall) begin
			acc <= '0;
		end else if (lin_r.gate) begin
			acc.xy.acc_x <= acc.xy.acc_x + (prod_x >>> shift);
			acc.xy.acc_y <= acc.xy.acc_y + (prod_y >>> shift);
		end
	end

	// write strobe one cycle after the registered gate falls
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			we <= 1'b0;
		end else begin
			we <= gate_fall;
		end
	end

	always_ff @(posedge dspif) begin
		if (gate_fall) begin
			wr_data.raw <= acc.raw;
		end
	end

	// pointer moves after each write and sticks at the last entry
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			ptr <= '0;
		end else if (resetacc) begin
			ptr <= '0;
		end else if (we && !lock_last) begin
			ptr <= ptr + 1'b1;
		end
	end

	// threshold on the sign of the x accumulator
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= we;
		end
	end

	always_ff @(posedge dspif) begin
		res_meas <= wr_data.xy.acc_x[acc_half_w-1];
	end

	always_comb begin
		wr.we     = we;
		wr.addr   = ptr;
		wr.data   = wr_data;
		res.valid = res_valid;
		res.meas  = res_meas;
	end

endmodule

// ==== meas_collect.sv ====
`timescale 1ns/1ns
/* merges the lane threshold bits into one shot-tagged measurement word */
module meas_collect (
	input  logic                           dspif,
	input  logic                           rst_n,
	input  dsp_types_pkg::lane_result_t    res_a,
	input  dsp_types_pkg::lane_result_t    res_b,
	input  logic [dsp_cfg_pkg::shot_w-1:0] shot,
	output dsp_types_pkg::meas_t           meas
);
	import dsp_cfg_pkg::*;

	logic [n_lane-1:0] mask_in;
	logic [n_lane-1:0] bits_in;
	logic              valid_q;
	logic [n_lane-1:0] mask_q;
	logic [n_lane-1:0] bits_q;
	logic [shot_w-1:0] shot_q;

	// lane a in bit 0, silent lanes read as zero
	always_comb begin
		mask_in = {res_b.valid, res_a.valid};
		bits_in = {res_b.meas & res_b.valid, res_a.meas & res_a.valid};
	end

	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= |mask_in;
		end
	end

	// payload held between words
	always_ff @(posedge dspif) begin
		if (|mask_in) begin
			mask_q <= mask_in;
			bits_q <= bits_in;
			shot_q <= shot;
		end
	end

	always_comb begin
		meas.valid = valid_q;
		meas.bits  = bits_q;
		meas.mask  = mask_q;
		meas.shot  = shot_q;
	end

endmodule

// ==== dsp_top.sv ====
`timescale 1ns/1ns
/* shot sequencer, two readout lanes and the measurement collector */
module dsp_top #(
	parameter int ACCBUF_ADDR_W = dsp_cfg_pkg::accbuf_addr_w
) (
	input  logic                            dspif,
	input  logic                            rst_n,
	input  logic                            stb_start,
	input  logic [dsp_cfg_pkg::shot_w-1:0]  nshot,
	input  logic                            proc_done,
	input  logic                            no_busy,
	input  logic                            resetacc,
	input  logic [dsp_cfg_pkg::shift_w-1:0] shift,
	input  dsp_types_pkg::lane_in_t         lane_a,
	input  dsp_types_pkg::lane_in_t         lane_b,
	output logic                            proc_reset,
	output logic [dsp_cfg_pkg::shot_w-1:0]  shot_cnt,
	output logic                            last_shot_done,
	output dsp_types_pkg::accbuf_wr_t       wr_a,
	output dsp_types_pkg::accbuf_wr_t       wr_b,
	output dsp_types_pkg::meas_t            meas
);
	import dsp_types_pkg::*;

	// threshold results toward the collector
	lane_result_t res_a;
	lane_result_t res_b;

	shot_sequencer i_seq (
		.dspif(dspif), .rst_n(rst_n), .stb_start(stb_start), .nshot(nshot),
		.proc_done(proc_done), .no_busy(no_busy), .proc_reset(proc_reset),
		.shot_cnt(shot_cnt), .last_shot_done(last_shot_done)
	);

	// both lanes share shift and resetacc
	readout_lane #(.ACCBUF_ADDR_W(ACCBUF_ADDR_W)) i_lane_a (
		.dspif(dspif), .rst_n(rst_n), .resetacc(resetacc), .shift(shift),
		.lin(lane_a), .wr(wr_a), .res(res_a)
	);

	readout_lane #(.ACCBUF_ADDR_W(ACCBUF_ADDR_W)) i_lane_b (
		.dspif(dspif), .rst_n(rst_n), .resetacc(resetacc), .shift(shift),
		.lin(lane_b), .wr(wr_b), .res(res_b)
	);

	// words tagged with the last finished shot index
	meas_collect i_coll (
		.dspif(dspif), .rst_n(rst_n), .res_a(res_a), .res_b(res_b),
		.shot(shot_cnt), .meas(meas)
	);

endmodule

// ==== dsp_assert.sv ====
`timescale 1ns/1ns
/* concurrent checks on sequencer start, lane write strobes, collector
   output and the last-shot-done level, bound into dsp_top */
module dsp_assert (
	input logic                         dspif,
	input logic                         rst_n,
	input logic                         stb_start,
	input logic                         proc_reset,
	input logic                         last_shot_done,
	input dsp_types_pkg::lane_in_t      lane_a,
	input dsp_types_pkg::lane_in_t      lane_b,
	input dsp_types_pkg::accbuf_wr_t    wr_a,
	input dsp_types_pkg::accbuf_wr_t    wr_b,
	input dsp_types_pkg::meas_t         meas
);
	// read back by the testbench at the end of the run
	int fail_cnt = 0;

	// last_shot_done high means the fsm sits in idle
	start_from_idle: assert property (@(posedge dspif) disable iff (!rst_n)
		stb_start && last_shot_done |=> !proc_reset)
		else begin
			$error("processors not released after start request in idle");
			fail_cnt++;
		end

	// one write per gate, two cycles after the input gate falls
	single_we_a: assert property (@(posedge dspif) disable iff (!rst_n)
		wr_a.we == ($past(lane_a.gate, 3) && !$past(lane_a.gate, 2)))
		else begin
			$error("lane a write strobe not aligned to its gate fall");
			fail_cnt++;
		end

	single_we_b: assert property (@(posedge dspif) disable iff (!rst_n)
		wr_b.we == ($past(lane_b.gate, 3) && !$past(lane_b.gate, 2)))
		else begin
			$error("lane b write strobe not aligned to its gate fall");
			fail_cnt++;
		end

	// lane result one cycle after the write, word one cycle later
	meas_follows: assert property (@(posedge dspif) disable iff (!rst_n)
		meas.valid == $past(wr_a.we || wr_b.we, 2))
		else begin
			$error("measurement word out of step with the lane writes");
			fail_cnt++;
		end

	// run end only seen with processors held
	ldone_in_reset: assert property (@(posedge dspif) disable iff (!rst_n)
		$rose(last_shot_done) |-> proc_reset)
		else begin
			$error("last_shot_done rose while processors were running");
			fail_cnt++;
		end

endmodule

bind dsp_top dsp_assert i_assert (
	.dspif(dspif), .rst_n(rst_n), .stb_start(stb_start), .proc_reset(proc_reset),
	.last_shot_done(last_shot_done), .lane_a(lane_a), .lane_b(lane_b),
	.wr_a(wr_a), .wr_b(wr_b), .meas(meas)
);

// ==== tb_dsp.sv ====
`timescale 1ns/1ns
/* testbench for dsp_top: clock, lfsr stimulus, processor model,
   reference accumulator, compare process and watchdog */
module tb_dsp;
	import dsp_cfg_pkg::*;
	import dsp_types_pkg::*;

	localparam int ptr_max = 2 ** accbuf_addr_w - 1;
	// cycle estimates, shot runs plus one slot per gate burst
	localparam int shot_budget = 200;
	localparam int burst_budget = 32;
	localparam int n_bursts = 22;
	localparam int budget = 20 + shot_budget + n_bursts * burst_budget;

	logic              dspif;
	logic              rst_n;
	logic              stb_start;
	logic [shot_w-1:0] nshot;
	logic              proc_done;
	logic              no_busy;
	logic              resetacc;
	logic [shift_w-1:0] shift;
	lane_in_t          lane_a;
	lane_in_t          lane_b;
	logic              proc_reset;
	logic [shot_w-1:0] shot_cnt;
	logic              last_shot_done;
	accbuf_wr_t        wr_a;
	accbuf_wr_t        wr_b;
	meas_t             meas;

	logic [15:0] lfsr = 16'd43;
	bit          slow_busy = 1'b0;
	string       cur_test = "reset";
	int          errors = 0;
	int          checks = 0;
	int          n_tests = 0;
	int          err0;
	int          chk0;
	// index of the last shot that went through shot-add
	int          exp_shot = 0;
	// gated samples per lane, and expected words in write order
	logic [sample_w-1:0] smp [2][32];
	logic [sample_w-1:0] lox [2][32];
	logic [sample_w-1:0] loy [2][32];
	logic [acc_w-1:0]    exp_mem [2][64];
	int                  wr_idx [2] = '{0, 0};
	int                  rd_idx [2] = '{0, 0};

	dsp_top #(.ACCBUF_ADDR_W(accbuf_addr_w)) i_dut (
		.dspif(dspif), .rst_n(rst_n), .stb_start(stb_start), .nshot(nshot),
		.proc_done(proc_done), .no_busy(no_busy), .resetacc(resetacc), .shift(shift),
		.lane_a(lane_a), .lane_b(lane_b), .proc_reset(proc_reset), .shot_cnt(shot_cnt),
		.last_shot_done(last_shot_done), .wr_a(wr_a), .wr_b(wr_b), .meas(meas)
	);

	initial begin
		dspif = 1'b0;
		forever #10 dspif = ~dspif;
	end

	// galois form, taps 16,14,13,11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	// sum of shifted sample*lo products, wrapping at 32 bits
	function automatic logic [31:0] ref_acc(input int l, input int n, input int sh,
		input bit use_y);
		logic signed [31:0] sum;
		logic signed [31:0] prod;
		int                 i;
		sum = '0;
		for (i = 0; i < n; i++) begin
			prod = $signed(smp[l][i]) * $signed(use_y ? loy[l][i] : lox[l][i]);
			sum = sum + (prod >>> sh);
		end
		return sum;
	endfunction

	task automatic check(input string what, input logic [63:0] want, input logic [63:0] act);
		checks++;
		if (want !== act) begin
			errors++;
			$display("ERROR %s %s: expected %0h, actual %0h", cur_test, what, want, act);
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		err0 = errors;
		chk0 = checks;
	endtask

	task automatic report_test();
		// every gated burst must have been written back
		check("pending_a", wr_idx[0], rd_idx[0]);
		check("pending_b", wr_idx[1], rd_idx[1]);
		n_tests++;
		$display("test %-8s %0d checks, %0d errors", cur_test, checks - chk0, errors - err0);
	endtask

	// processors finish 3..6 cycles into the shot
	initial begin : proc_model
		int dly;
		proc_done = 1'b0;
		no_busy = 1'b1;
		forever begin
			@(negedge proc_reset);
			dly = 3 + int'(rand_bits(2));
			repeat (dly) @(posedge dspif);
			#2 proc_done = 1'b1;
			if (slow_busy)
				no_busy = 1'b0;
			wait (proc_reset === 1'b1);
			#2 proc_done = 1'b0;
			if (slow_busy) begin
				repeat (4) @(posedge dspif);
				#2 no_busy = 1'b1;
			end
		end
	end

	// start a run of n shots, count processor release pulses
	task automatic run_shots(input int n, input bit slow);
		int   pulses;
		logic prev;
		slow_busy = slow;
		@(posedge dspif);
		#2 nshot = n;
		@(posedge dspif);
		#2 stb_start = 1'b1;
		@(posedge dspif);
		#2 stb_start = 1'b0;
		check("ldone_clear", 0, last_shot_done);
		pulses = 0;
		prev = 1'b1;
		while (!last_shot_done) begin
			@(negedge dspif);
			if (prev && !proc_reset) begin
				pulses++;
				// index of the previous shot is published before each restart
				if (pulses > 1)
					check("shot_cnt", pulses - 2, shot_cnt);
			end
			prev = proc_reset;
		end
		check("pulses", n, pulses);
		check("proc_reset", 1, proc_reset);
		// the final shot ends in done, so the last published index is n-2
		if (n > 1)
			exp_shot = n - 2;
		repeat (5) begin
			@(negedge dspif);
			check("ldone_hold", 1, last_shot_done);
		end
	endtask

	// both lanes gated at once with independent random lengths
	task automatic burst(input int sh);
		int       len [2];
		int       lmax;
		int       c;
		int       l;
		lane_in_t li [2];
		len[0] = 4 + int'(rand_bits(4));
		len[1] = 4 + int'(rand_bits(4));
		lmax = (len[0] > len[1]) ? len[0] : len[1];
		for (c = 0; c < lmax + 6; c++) begin
			@(posedge dspif);
			#2 shift = shift_w'(sh);
			for (l = 0; l < 2; l++) begin
				li[l] = '0;
				if (c < len[l]) begin
					smp[l][c] = 16'(rand_bits(16));
					lox[l][c] = 16'(rand_bits(16));
					loy[l][c] = 16'(rand_bits(16));
					li[l].sample = smp[l][c];
					li[l].lo_x = lox[l][c];
					li[l].lo_y = loy[l][c];
					li[l].gate = 1'b1;
				end else if (c == len[l]) begin
					// gate drops now, write lands two cycles later
					exp_mem[l][wr_idx[l]] = {ref_acc(l, len[l], sh, 0),
						ref_acc(l, len[l], sh, 1)};
					wr_idx[l]++;
				end
			end
			lane_a = li[0];
			lane_b = li[1];
		end
	endtask

	// writes, pointer and measurement words, sampled mid-cycle
	initial begin : compare
		int               l;
		int               exp_ptr [2];
		logic [acc_w-1:0] want;
		accbuf_wr_t       w;
		logic [1:0]       nm;
		logic [1:0]       nb;
		logic [1:0]       pm0;
		logic [1:0]       pb0;
		logic [1:0]       pm1;
		logic [1:0]       pb1;
		exp_ptr = '{0, 0};
		pm0 = '0;
		pb0 = '0;
		pm1 = '0;
		pb1 = '0;
		forever begin
			@(negedge dspif);
			if (rst_n) begin
				nm = '0;
				nb = '0;
				for (l = 0; l < 2; l++) begin
					w = (l == 0) ? wr_a : wr_b;
					if (w.we && rd_idx[l] == wr_idx[l]) begin
						errors++;
						$display("lane %0d wrote a result with no gate behind it in test %s",
							l, cur_test);
					end else if (w.we) begin
						want = exp_mem[l][rd_idx[l]];
						rd_idx[l]++;
						check("acc_x", want[63:32], {32'd0, w.data.xy.acc_x});
						check("acc_y", want[31:0], {32'd0, w.data.xy.acc_y});
						check("addr", exp_ptr[l], w.addr);
						nm[l] = 1'b1;
						nb[l] = want[63];
					end
					// pointer steps after a write, sticks at the top, clears on resetacc
					if (resetacc)
						exp_ptr[l] = 0;
					else if (w.we && exp_ptr[l] != ptr_max)
						exp_ptr[l]++;
				end
				// word two cycles behind the writes
				check("meas_valid", |pm1, meas.valid);
				if (meas.valid) begin
					check("meas_mask", pm1, meas.mask);
					check("meas_bits", pb1, meas.bits);
					check("meas_shot", exp_shot, meas.shot);
				end
				pm1 = pm0;
				pb1 = pb0;
				pm0 = nm;
				pb0 = nb;
			end
		end
	end

	initial begin : watchdog
		repeat (2 * budget) @(posedge dspif);
		$display("timeout after %0d cycles, test %s never finished", 2 * budget, cur_test);
		$display("Simulation failed");
		$finish;
	end

	initial begin : main
		int afail;
		rst_n = 1'b0;
		stb_start = 1'b0;
		nshot = '0;
		resetacc = 1'b0;
		shift = '0;
		lane_a = '0;
		lane_b = '0;
		repeat (2) @(posedge dspif);
		#2 rst_n = 1'b1;
		start_test("reset");
		@(negedge dspif);
		check("proc_reset", 1, proc_reset);
		check("ldone", 0, last_shot_done);
		check("we", 0, {wr_a.we, wr_b.we});
		check("addr", 0, {wr_a.addr, wr_b.addr});
		report_test();
		start_test("shots2");
		run_shots(2, 1'b0);
		report_test();
		// starts with last_shot_done still high from the run before
		start_test("shots3");
		run_shots(3, 1'b1);
		report_test();
		start_test("shift0");
		repeat (4) burst(0);
		report_test();
		start_test("shift3");
		repeat (4) burst(3);
		report_test();
		// 20 writes so far, pointer must be parked at the top
		start_test("ptr_lock");
		repeat (12) burst(1);
		@(negedge dspif);
		check("lock_a", ptr_max, wr_a.addr);
		check("lock_b", ptr_max, wr_b.addr);
		report_test();
		start_test("resetacc");
		@(posedge dspif);
		#2 resetacc = 1'b1;
		@(posedge dspif);
		#2 resetacc = 1'b0;
		@(negedge dspif);
		check("clr_a", 0, wr_a.addr);
		check("clr_b", 0, wr_b.addr);
		repeat (2) burst(2);
		report_test();
		afail = i_dut.i_assert.fail_cnt;
		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
			n_tests, checks, errors, afail);
		if (errors == 0 && afail == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== flist.f ====
dsp_cfg_pkg.sv
dsp_types_pkg.sv
shot_sequencer.sv
readout_lane.sv
meas_collect.sv
dsp_top.sv
dsp_assert.sv
tb_dsp.sv

// ==== run.sh ====
#!/bin/sh
# build tb_dsp with verilator, run it, and decide on the log contents
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_dsp -Mdir obj_dir -o tb_dsp \
	-f flist.f && ./obj_dir/tb_dsp > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Simulation passed$" sim.log && echo "run ok" || { echo "run not ok"; exit 1; }
